/* rtl/Alu.sv */
module Alu import cpuPkg::*; (
    input  opcode_t    opcode,
    input  word_t      rsData,
    input  word_t      rtData,
    input  logic [7:0] imm8,
    input  logic       ALUSrc,
    input  logic       ALUSrc8bit,
    output word_t      aluResult,
    output flags_t     aluFlags
);

    // nibble add clamped to -8..7
    function automatic logic [3:0] satAdd4(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] s;
        s = a + b;
        if (a[3] == b[3] && s[3] != a[3])
            return a[3] ? 4'b1000 : 4'b0111;
        return s;
    endfunction

    word_t       opB;        // rt or sign-extended imm4
    logic [3:0]  shamt;
    word_t       sum;
    word_t       diff;
    logic        addOvf;
    logic        subOvf;
    word_t       addSat;
    word_t       subSat;
    word_t       redSum;
    word_t       paddsb;
    logic [31:0] rotWide;    // doubled word for rotate
    word_t       byteLoad;
    word_t       memAddr;
    word_t       result;

    assign opB   = ALUSrc ? {{12{imm8[3]}}, imm8[3:0]} : rtData;
    assign shamt = opB[3:0];

    // saturating add and subtract
    assign sum    = rsData + opB;
    assign diff   = rsData - opB;
    assign addOvf = (rsData[15] == opB[15]) && (sum[15] != rsData[15]);
    assign subOvf = (rsData[15] != opB[15]) && (diff[15] != rsData[15]);
    assign addSat = addOvf ? (rsData[15] ? WORD_MIN : WORD_MAX) : sum;
    assign subSat = subOvf ? (rsData[15] ? WORD_MIN : WORD_MAX) : diff;

    // sum of four signed bytes, cannot overflow 16 bits
    assign redSum = {{8{rsData[15]}}, rsData[15:8]}
                  + {{8{rsData[7]}}, rsData[7:0]}
                  + {{8{rtData[15]}}, rtData[15:8]}
                  + {{8{rtData[7]}}, rtData[7:0]};

    // four lanes, no carry between them
    assign paddsb = {satAdd4(rsData[15:12], rtData[15:12]),
                     satAdd4(rsData[11:8], rtData[11:8]),
                     satAdd4(rsData[7:4], rtData[7:4]),
                     satAdd4(rsData[3:0], rtData[3:0])};

    assign rotWide = {rsData, rsData} >> shamt;

    // rtData holds rd here
    assign byteLoad = (opcode == OP_LHB) ? {imm8, rtData[7:0]} : {rtData[15:8], imm8};

    // base forced even, offset counted in words
    assign memAddr = {rsData[15:1], 1'b0} + {opB[14:0], 1'b0};

    always_comb begin
        if (ALUSrc8bit) begin
            result = byteLoad;
        end else begin
            case (opcode)
                OP_ADD:    result = addSat;
                OP_SUB:    result = subSat;
                OP_XOR:    result = rsData ^ rtData;
                OP_RED:    result = redSum;
                OP_SLL:    result = rsData << shamt;
                OP_SRA:    result = word_t'($signed(rsData) >>> shamt);
                OP_ROR:    result = rotWide[15:0];
                OP_PADDSB: result = paddsb;
                OP_LW,
                OP_SW:     result = memAddr;
                default:   result = '0;      // branches, pcs, hlt
            endcase
        end
    end

    assign aluResult = result;

    // raw flags, Retire picks which ones stick
    always_comb begin
        aluFlags         = '0;
        aluFlags[FLAG_Z] = (result == '0);
        if (opcode == OP_ADD) begin
            aluFlags[FLAG_V] = addOvf;
            aluFlags[FLAG_N] = result[15];
        end else if (opcode == OP_SUB) begin
            aluFlags[FLAG_V] = subOvf;
            aluFlags[FLAG_N] = result[15];
        end
    end

endmodule

/* rtl/Control.sv */
module Control import cpuPkg::*; (
    input  opcode_t instruction,
    output logic    RegWrite,
    output logic    MemRead,
    output logic    MemWrite,
    output logic    Branch,
    output logic    BranchReg,
    output logic    MemtoReg,
    output logic    ALUSrc,
    output logic    pcs_select,
    output logic    hlt_select,
    output logic    ALUSrc8bit
);

    // everything off, then switch on per opcode
    always_comb begin
        RegWrite   = 1'b0;
        MemRead    = 1'b0;
        MemWrite   = 1'b0;
        Branch     = 1'b0;
        BranchReg  = 1'b0;
        MemtoReg   = 1'b0;
        ALUSrc     = 1'b0;
        pcs_select = 1'b0;
        hlt_select = 1'b0;
        ALUSrc8bit = 1'b0;

        case (instruction)
            // two register ops
            OP_ADD, OP_SUB, OP_XOR, OP_RED, OP_PADDSB: begin
                RegWrite = 1'b1;
            end
            // shifts by 4-bit immediate
            OP_SLL, OP_SRA, OP_ROR: begin
                RegWrite = 1'b1;
                ALUSrc   = 1'b1;
            end
            OP_LLB, OP_LHB: begin
                RegWrite   = 1'b1;
                ALUSrc8bit = 1'b1;   // also routes rd to read port 2
            end
            OP_LW: begin
                RegWrite = 1'b1;
                MemRead  = 1'b1;
                MemtoReg = 1'b1;     // load data to rd
                ALUSrc   = 1'b1;     // offset into address
            end
            OP_SW: begin
                MemWrite = 1'b1;     // rd is store data
                ALUSrc   = 1'b1;
            end
            OP_B: begin
                Branch = 1'b1;
            end
            OP_BR: begin
                BranchReg = 1'b1;
            end
            OP_PCS: begin
                RegWrite   = 1'b1;   // rd gets return address
                pcs_select = 1'b1;
            end
            OP_HLT: begin
                hlt_select = 1'b1;
            end
            default: begin
                RegWrite = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/CpuCore.sv */
module CpuCore import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    instr,
    output word_t    pc,
    output word_t    memAddr,
    output word_t    memWdata,
    input  word_t    memRdata,
    output logic     memRe,
    output logic     memWe,
    output logic     wbEn,
    output regAddr_t wbReg,
    output word_t    wbData,
    output logic     halted
);

    opcode_t  opcode;
    regAddr_t rdAddr;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    regAddr_t rtSel;         // rd for byte loads and stores
    logic     RegWrite;
    logic     MemRead;
    logic     MemWrite;
    logic     Branch;
    logic     BranchReg;
    logic     MemtoReg;
    logic     ALUSrc;
    logic     pcs_select;
    logic     hlt_select;
    logic     ALUSrc8bit;
    word_t    rsData;
    word_t    rtData;
    word_t    aluResult;
    flags_t   aluFlags;
    logic     commitOk;      // not in reset, not halted

    // instruction fields
    assign opcode = instr[15:12];
    assign rdAddr = instr[11:8];
    assign rsAddr = instr[7:4];
    assign rtAddr = instr[3:0];
    assign rtSel  = (ALUSrc8bit || MemWrite) ? rdAddr : rtAddr;

    Control ctrl (
        .instruction(opcode),
        .RegWrite   (RegWrite),
        .MemRead    (MemRead),
        .MemWrite   (MemWrite),
        .Branch     (Branch),
        .BranchReg  (BranchReg),
        .MemtoReg   (MemtoReg),
        .ALUSrc     (ALUSrc),
        .pcs_select (pcs_select),
        .hlt_select (hlt_select),
        .ALUSrc8bit (ALUSrc8bit)
    );

    RegisterFile regFile (
        .clk   (clk),
        .rst   (rst),
        .rsAddr(rsAddr),
        .rtAddr(rtSel),
        .wbReg (wbReg),
        .wbEn  (wbEn),
        .wbData(wbData),
        .rsData(rsData),
        .rtData(rtData)
    );

    Alu alu (
        .opcode    (opcode),
        .rsData    (rsData),
        .rtData    (rtData),
        .imm8      (instr[7:0]),
        .ALUSrc    (ALUSrc),
        .ALUSrc8bit(ALUSrc8bit),
        .aluResult (aluResult),
        .aluFlags  (aluFlags)
    );

    Retire retire (
        .clk         (clk),
        .rst         (rst),
        .RegWrite    (RegWrite),
        .MemtoReg    (MemtoReg),
        .Branch      (Branch),
        .BranchReg   (BranchReg),
        .pcs_select  (pcs_select),
        .hlt_select  (hlt_select),
        .opcode      (opcode),
        .cond        (instr[11:9]),
        .branchOffset(instr[8:0]),
        .rsData      (rsData),
        .aluResult   (aluResult),
        .memRdata    (memRdata),
        .aluFlags    (aluFlags),
        .rdAddr      (rdAddr),
        .pc          (pc),
        .halted      (halted),
        .wbEn        (wbEn),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .commitOk    (commitOk)
    );

    // data memory side
    assign memAddr  = aluResult;     // LW/SW address from the ALU
    assign memWdata = rtData;        // rd on a store
    assign memRe    = MemRead && commitOk;
    assign memWe    = MemWrite && commitOk;

endmodule

/* rtl/RegisterFile.sv */
module RegisterFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    input  regAddr_t wbReg,
    input  logic     wbEn,
    input  word_t    wbData,
    output word_t    rsData,
    output word_t    rtData
);

    word_t regs [REG_COUNT];

    // single write port, r0 never stored
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    // no bypass, same-cycle write shows next cycle
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

/* rtl/Retire.sv */
module Retire import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       RegWrite,
    input  logic       MemtoReg,
    input  logic       Branch,
    input  logic       BranchReg,
    input  logic       pcs_select,
    input  logic       hlt_select,
    input  opcode_t    opcode,
    input  cond_t      cond,
    input  logic [8:0] branchOffset,
    input  word_t      rsData,
    input  word_t      aluResult,
    input  word_t      memRdata,
    input  flags_t     aluFlags,
    input  regAddr_t   rdAddr,
    output word_t      pc,
    output logic       halted,
    output logic       wbEn,
    output regAddr_t   wbReg,
    output word_t      wbData,
    output logic       commitOk
);

    flags_t flags;           // state before the current instruction
    flags_t nextFlags;
    word_t  pcPlus2;
    word_t  branchTarget;
    word_t  nextPc;
    logic   condMet;
    logic   setZ;
    logic   setVN;

    assign commitOk = !rst && !halted;  // also gates memory strobes in the core

    assign pcPlus2      = pc + PC_STEP;
    assign branchTarget = pcPlus2 + {{6{branchOffset[8]}}, branchOffset, 1'b0};

    always_comb begin
        case (cond)
            COND_NE: condMet = !flags[FLAG_Z];
            COND_EQ: condMet = flags[FLAG_Z];
            COND_GT: condMet = !flags[FLAG_Z] && !flags[FLAG_N];
            COND_LT: condMet = flags[FLAG_N];
            COND_GE: condMet = flags[FLAG_Z] || !flags[FLAG_N];
            COND_LE: condMet = flags[FLAG_Z] || flags[FLAG_N];
            COND_OV: condMet = flags[FLAG_V];
            COND_AL: condMet = 1'b1;
        endcase
    end

    always_comb begin
        nextPc = pcPlus2;
        if (hlt_select)
            nextPc = pc;                         // park on the HLT
        else if (Branch && condMet)
            nextPc = branchTarget;
        else if (BranchReg && condMet)
            nextPc = {rsData[15:1], 1'b0};       // keep word aligned
    end

    // Z from arithmetic, logic and shifts, V and N from add and sub only
    assign setZ  = opcode inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR};
    assign setVN = opcode inside {OP_ADD, OP_SUB};

    always_comb begin
        nextFlags = flags;
        if (setZ)
            nextFlags[FLAG_Z] = aluFlags[FLAG_Z];
        if (setVN) begin
            nextFlags[FLAG_V] = aluFlags[FLAG_V];
            nextFlags[FLAG_N] = aluFlags[FLAG_N];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            flags  <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            pc     <= nextPc;
            flags  <= nextFlags;
            halted <= hlt_select;    // sticky until reset
        end
    end

    // write back
    assign wbEn   = RegWrite && commitOk;
    assign wbReg  = rdAddr;
    assign wbData = MemtoReg ? memRdata : (pcs_select ? pcPlus2 : aluResult);

    assert property (@(posedge clk) disable iff (rst) !pc[0]);

endmodule

/* rtl/cpuPkg.sv */
package cpuPkg;

    // data path and addressing
    typedef logic [15:0] word_t;
    typedef logic [3:0]  regAddr_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [2:0]  cond_t;
    typedef logic [2:0]  flags_t;      // {Z, V, N}

    localparam int    REG_COUNT = 16;
    localparam word_t PC_STEP   = 16'd2;   // bytes per instruction

    // saturation limits for 16-bit signed math
    localparam word_t WORD_MAX = 16'h7fff;
    localparam word_t WORD_MIN = 16'h8000;

    // bit positions inside flags_t
    localparam int FLAG_Z = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_N = 0;

    // opcodes, top nibble of the instruction word
    localparam opcode_t OP_ADD    = 4'b0000;
    localparam opcode_t OP_SUB    = 4'b0001;
    localparam opcode_t OP_XOR    = 4'b0010;
    localparam opcode_t OP_RED    = 4'b0011;
    localparam opcode_t OP_SLL    = 4'b0100;
    localparam opcode_t OP_SRA    = 4'b0101;
    localparam opcode_t OP_ROR    = 4'b0110;
    localparam opcode_t OP_PADDSB = 4'b0111;
    localparam opcode_t OP_LW     = 4'b1000;
    localparam opcode_t OP_SW     = 4'b1001;
    localparam opcode_t OP_LLB    = 4'b1010;
    localparam opcode_t OP_LHB    = 4'b1011;
    localparam opcode_t OP_B      = 4'b1100;
    localparam opcode_t OP_BR     = 4'b1101;
    localparam opcode_t OP_PCS    = 4'b1110;
    localparam opcode_t OP_HLT    = 4'b1111;

    // branch conditions, instruction bits [11:9]
    localparam cond_t COND_NE = 3'b000;    // Z clear
    localparam cond_t COND_EQ = 3'b001;    // Z set
    localparam cond_t COND_GT = 3'b010;    // Z and N clear
    localparam cond_t COND_LT = 3'b011;    // N set
    localparam cond_t COND_GE = 3'b100;    // Z set or N clear
    localparam cond_t COND_LE = 3'b101;    // Z set or N set
    localparam cond_t COND_OV = 3'b110;    // V set
    localparam cond_t COND_AL = 3'b111;    // unconditional

endpackage

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal -f verilog.f --top-module tbCpuCore -o simCpuCore &&
./obj_dir/simCpuCore | tee /dev/stderr | grep -q "All tests passed" &&
echo "RESULT: PASS" ||
{ echo "RESULT: FAIL"; exit 1; }

/* sim/CoreChecker.sv */
module CoreChecker import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] section,
    input  logic       endRun,
    input  word_t      instr,
    input  word_t      pc,
    input  word_t      memAddr,
    input  word_t      memWdata,
    input  word_t      memRdata,
    input  logic       memRe,
    input  logic       memWe,
    input  logic       wbEn,
    input  regAddr_t   wbReg,
    input  word_t      wbData,
    input  logic       halted,
    output int         errorCount
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t  regs [REG_COUNT];    // architectural model
    flags_t flags;
    word_t  mpc;
    logic   mhalt;
    int     checks [5] = '{default: 0};
    int     errs [5] = '{default: 0};
    int     lastSec = 0;
    logic   reported = 1'b0;
    string  secName [5] = '{"reset", "alu write-back", "memory", "branches", "pcs and hlt"};

    assign errorCount = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];

    task automatic compareValue(input string name, input word_t got, input word_t exp);
        checks[section]++;
        if (got !== exp) begin
            errs[section]++;
            $display("Mismatch %s: got %h, expected %h at pc %h", name, got, exp, pc);
        end
    endtask

    task automatic reportSection(input int s);
        $display("test %0d %s: %0d checks, %0d errors", s, secName[s], checks[s], errs[s]);
    endtask

    function automatic word_t byteSum(input word_t a, input word_t b);
        int s;
        s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
          + int'($signed(b[15:8])) + int'($signed(b[7:0]));
        return word_t'(s);
    endfunction

    function automatic word_t nibbleSat(input word_t a, input word_t b);
        word_t r;
        int    s;
        for (int i = 0; i < 4; i++) begin
            s = int'($signed(a[i*4 +: 4])) + int'($signed(b[i*4 +: 4]));
            s = (s > 7) ? 7 : ((s < -8) ? -8 : s);     // clamp each lane
            r[i*4 +: 4] = 4'(s);
        end
        return r;
    endfunction

    function automatic logic condHolds(input cond_t c, input flags_t f);
        case (c)
            COND_NE: return !f[FLAG_Z];
            COND_EQ: return f[FLAG_Z];
            COND_GT: return !f[FLAG_Z] && !f[FLAG_N];
            COND_LT: return f[FLAG_N];
            COND_GE: return f[FLAG_Z] || !f[FLAG_N];
            COND_LE: return f[FLAG_Z] || f[FLAG_N];
            COND_OV: return f[FLAG_V];
            default: return 1'b1;                      // always
        endcase
    endfunction

    // outputs settle mid-cycle, the model steps here too
    always @(negedge clk) begin
        opcode_t  op;
        regAddr_t rd;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    nextPc;
        int       wide;
        logic     ovf;
        logic     writes;
        int       total;
        int       bad;
        op = instr[15:12];
        rd = instr[11:8];
        a  = regs[instr[7:4]];
        b  = regs[instr[3:0]];
        if (int'(section) != lastSec) begin            // previous test just ended
            reportSection(lastSec);
            lastSec = int'(section);
        end
        if (rst) begin
            compareValue("pc", pc, '0);
            compareValue("wbEn", word_t'(wbEn), '0);
            compareValue("memRe", word_t'(memRe), '0);
            compareValue("memWe", word_t'(memWe), '0);
            compareValue("halted", word_t'(halted), '0);
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] = '0;
            flags = '0;
            mpc   = '0;
            mhalt = 1'b0;
        end else if (mhalt) begin
            compareValue("halted", word_t'(halted), 16'd1);
            compareValue("pc", pc, mpc);               // parked on the HLT
            compareValue("wbEn", word_t'(wbEn), '0);
            compareValue("memRe", word_t'(memRe), '0);
            compareValue("memWe", word_t'(memWe), '0);
        end else begin
            compareValue("pc", pc, mpc);
            compareValue("halted", word_t'(halted), '0);
            res    = '0;
            ovf    = 1'b0;
            writes = 1'b1;
            nextPc = mpc + PC_STEP;
            case (op)
                OP_ADD, OP_SUB: begin
                    wide = (op == OP_ADD) ? int'($signed(a)) + int'($signed(b))
                                          : int'($signed(a)) - int'($signed(b));
                    ovf  = (wide > 32767) || (wide < -32768);
                    res  = ovf ? ((wide > 0) ? 16'h7fff : 16'h8000) : word_t'(wide);
                end
                OP_XOR:    res = a ^ b;
                OP_RED:    res = byteSum(a, b);
                OP_SLL:    res = a << instr[3:0];
                OP_SRA:    res = (a >> instr[3:0]) | ({16{a[15]}} & ~(16'hffff >> instr[3:0]));
                OP_ROR:    res = (a >> instr[3:0]) | (a << (5'd16 - instr[3:0]));
                OP_PADDSB: res = nibbleSat(a, b);
                OP_LLB:    res = {regs[rd][15:8], instr[7:0]};
                OP_LHB:    res = {instr[7:0], regs[rd][7:0]};
                OP_LW, OP_SW: begin
                    compareValue("memAddr", memAddr,
                                 {a[15:1], 1'b0} + {{11{instr[3]}}, instr[3:0], 1'b0});
                    res = memRdata;                    // loaded word
                    if (op == OP_SW) begin
                        compareValue("memWdata", memWdata, regs[rd]);
                        writes = 1'b0;
                    end
                end
                OP_B: begin
                    writes = 1'b0;
                    if (condHolds(instr[11:9], flags))
                        nextPc = mpc + PC_STEP + word_t'(2 * int'($signed(instr[8:0])));
                end
                OP_BR: begin
                    writes = 1'b0;
                    if (condHolds(instr[11:9], flags))
                        nextPc = a & 16'hfffe;         // rs, word aligned
                end
                OP_PCS:    res = mpc + PC_STEP;
                default: begin                         // HLT
                    writes = 1'b0;
                    nextPc = mpc;
                    mhalt  = 1'b1;
                end
            endcase
            if (op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR})
                flags[FLAG_Z] = (res == '0);
            if (op inside {OP_ADD, OP_SUB}) begin
                flags[FLAG_V] = ovf;
                flags[FLAG_N] = res[15];
            end
            compareValue("wbEn", word_t'(wbEn), word_t'(writes));
            compareValue("memRe", word_t'(memRe), word_t'(op == OP_LW));
            compareValue("memWe", word_t'(memWe), word_t'(op == OP_SW));
            if (writes) begin
                compareValue("wbReg", word_t'(wbReg), word_t'(rd));
                compareValue("wbData", wbData, res);
                if (rd != '0)
                    regs[rd] = res;                    // r0 stays zero
            end
            mpc = nextPc;
        end
        if (endRun && !reported) begin
            reportSection(lastSec);
            total = 0;
            bad   = 0;
            for (int s = 0; s < 5; s++) begin
                total += checks[s];
                bad   += errs[s];
            end
            $display("totals: %0d checks, %0d errors", total, bad);
            reported = 1'b1;
        end
    end

endmodule

/* sim/tbCpuCore.sv */
module tbCpuCore import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    word_t      instr;
    word_t      pc;
    word_t      memAddr;
    word_t      memWdata;
    word_t      memRdata;
    logic       memRe;
    logic       memWe;
    logic       wbEn;
    regAddr_t   wbReg;
    word_t      wbData;
    logic       halted;
    logic [2:0] section;         // test the current pc belongs to, 0 is reset
    logic       endRun = 1'b0;
    int         errorCount;

    word_t  imem [256];          // instruction memory, word addressed
    word_t  dmem [256];
    int     secStart [5];        // first word of each test's code
    int     wp;                  // next free instruction slot
    integer seed = 32'hf876d430;

    always #50 clk = ~clk;

    CpuCore UUT (.*);

    CoreChecker coreCheck (.*);

    // both memories answer within the cycle
    assign instr    = imem[pc[8:1]];
    assign memRdata = dmem[memAddr[8:1]];

    always @(posedge clk) begin
        if (memWe)
            dmem[memAddr[8:1]] <= memWdata;
    end

    always_comb begin
        section = 3'd0;
        if (!rst) begin
            for (int s = 1; s < 5; s++) begin
                if (int'(pc[8:1]) >= secStart[s])
                    section = 3'(s);
            end
        end
    end

    task automatic putInstr(input word_t w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic buildProgram();
        opcode_t     aluOps [10] = '{OP_ADD, OP_SUB, OP_XOR, OP_RED, OP_PADDSB,
                                     OP_SLL, OP_SRA, OP_ROR, OP_LLB, OP_LHB};
        logic [31:0] r;
        int          skip;
        int          target;
        for (int i = 0; i < 256; i++) begin
            imem[i] = word_t'($random(seed));          // junk past the HLT
            dmem[i] = word_t'(i * 40503) ^ 16'h3c5a;
        end
        wp = 0;
        secStart[1] = wp;
        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            putInstr({aluOps[r[31:16] % 10], r[11:0]});   // any rd, r0 included
        end
        secStart[2] = wp;
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            putInstr({r[16] ? OP_LW : OP_SW, r[11:0]});
        end
        secStart[3] = wp;
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            skip = int'(r[23:20]) % 3;                    // fillers jumped over
            putInstr({r[17] ? OP_ADD : OP_SUB, 4'(r[11:8] % 13), r[7:0]});  // fresh flags
            if (r[18]) begin
                putInstr({OP_B, r[26:24], 9'(skip)});
            end else begin
                target = 2 * (wp + 3 + skip);             // r14 holds the BR target
                putInstr({OP_LLB, 4'd14, 8'(target)});
                putInstr({OP_LHB, 4'd14, 8'(target >> 8)});
                putInstr({OP_BR, r[26:24], 1'b0, 4'd14, 4'd0});
            end
            putInstr({OP_XOR, 4'(r[30:27] % 13), r[7:0]});
            putInstr({OP_XOR, 4'(r[15:12] % 13), r[3:0], r[7:4]});
        end
        secStart[4] = wp;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            putInstr({OP_PCS, r[11:0]});
        end
        putInstr({OP_HLT, 12'h000});
    endtask

    initial begin
        int cycles;
        buildProgram();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!halted && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: core did not halt within 1000 cycles");
            $display("Some tests failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);     // frozen state stays watched
            endRun <= 1'b1;
            @(posedge clk);                // checker reports in between
            if (errorCount == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

/* verilog.f */
rtl/cpuPkg.sv
rtl/Control.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/Retire.sv
rtl/CpuCore.sv
sim/CoreChecker.sv
sim/tbCpuCore.sv
